// File: Bender.yml
package:
  name: retire_core

sources:
  - rob_pkg.sv
  - tag_cam.sv
  - free_list.sv
  - rob.sv
  - retire_core.sv
  - target: test
    files:
      - retire_core_tb.sv

// File: free_list.sv
`default_nettype none

module free_list (
	input wire logic clock,
	input wire logic rst,
	input wire logic [rob_pkg::ss_width-1:0] pop,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] alloc_tag,
	input wire logic [rob_pkg::ss_width-1:0] push,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] push_tag,
	output logic [6:0] free_count
);

	// Circular queue of free tags, one slot per physical register
	logic [rob_pkg::phys_tag_bits-1:0] tag_mem [rob_pkg::num_phys_regs];

	logic [$clog2(rob_pkg::num_phys_regs)-1:0] rd_ptr;
	logic [$clog2(rob_pkg::num_phys_regs)-1:0] rd_ptr_next_slot;
	logic [$clog2(rob_pkg::num_phys_regs)-1:0] wr_ptr;
	logic [$clog2(rob_pkg::num_phys_regs)-1:0] wr_ptr_lane1;

	logic [1:0] n_pop;
	logic [1:0] n_push;

	assign rd_ptr_next_slot = rd_ptr + 1'b1;

	// Lane 1 writes behind lane 0 only when lane 0 also pushes
	assign wr_ptr_lane1 = wr_ptr + {5'd0, push[0]};

	assign n_pop = {1'b0, pop[0]} + {1'b0, pop[1]};
	assign n_push = {1'b0, push[0]} + {1'b0, push[1]};

	// Head tags for the two lanes.
	// A lone lane 1 pop takes the head itself, so each lane always sees
	// the tag it will actually receive
	always_comb begin
		alloc_tag[0] = tag_mem[rd_ptr];
		if (pop[0]) begin
			alloc_tag[1] = tag_mem[rd_ptr_next_slot];
		end else begin
			alloc_tag[1] = tag_mem[rd_ptr];
		end
	end

	// Queue storage
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < rob_pkg::free_regs_at_reset; i++) begin
				tag_mem[i] <= rob_pkg::phys_tag_bits'(rob_pkg::first_free_tag + i);
			end
		end else begin
			if (push[0]) begin
				tag_mem[wr_ptr] <= push_tag[0];
			end
			if (push[1]) begin
				tag_mem[wr_ptr_lane1] <= push_tag[1];
			end
		end
	end

	// Pointers and count
	always_ff @(posedge clock) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= $clog2(rob_pkg::num_phys_regs)'(rob_pkg::free_regs_at_reset);
			free_count <= 7'(rob_pkg::free_regs_at_reset);
		end else begin
			rd_ptr <= rd_ptr + {4'd0, n_pop};
			wr_ptr <= wr_ptr + {4'd0, n_push};
			free_count <= free_count + {5'd0, n_push} - {5'd0, n_pop};
		end
	end

endmodule

`default_nettype wire

// File: retire_core.sv
`default_nettype none

module retire_core (
	input wire logic clock,
	input wire logic rst,

	// Dispatch side
	input wire logic [rob_pkg::ss_width-1:0] dispatch_req,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] old_tag,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::arch_idx_bits-1:0] arch_dest,
	input wire logic [rob_pkg::ss_width-1:0] halt,
	output logic [rob_pkg::ss_width-1:0] dispatch_grant,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] alloc_tag,

	// Completion bus
	input wire logic [rob_pkg::ss_width-1:0] complete_valid,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] complete_tag,

	// Retire side
	output logic [rob_pkg::ss_width-1:0] retire_valid,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] retire_old_tag,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] retire_new_tag,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::arch_idx_bits-1:0] retire_arch_dest,
	output logic [rob_pkg::ss_width-1:0] retire_halt,

	output logic [rob_pkg::rob_count_bits-1:0] free_rows,
	output logic [6:0] free_count
);

	// Grants pop new tags, retires push back the old ones
	free_list u_free_list (
		.clock      (clock),
		.rst        (rst),
		.pop        (dispatch_grant),
		.alloc_tag  (alloc_tag),
		.push       (retire_valid),
		.push_tag   (retire_old_tag),
		.free_count (free_count)
	);

	rob u_rob (
		.clock            (clock),
		.rst              (rst),
		.dispatch_req     (dispatch_req),
		.new_tag          (alloc_tag),
		.old_tag          (old_tag),
		.arch_dest        (arch_dest),
		.halt             (halt),
		.free_tags        (free_count),
		.dispatch_grant   (dispatch_grant),
		.complete_valid   (complete_valid),
		.complete_tag     (complete_tag),
		.retire_valid     (retire_valid),
		.retire_old_tag   (retire_old_tag),
		.retire_new_tag   (retire_new_tag),
		.retire_arch_dest (retire_arch_dest),
		.retire_halt      (retire_halt),
		.free_rows        (free_rows)
	);

endmodule

`default_nettype wire

// File: retire_core_tb.sv
`default_nettype none

module retire_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Completion selectors besides a dispatch sequence number
	localparam int no_comp = -1;
	localparam int rand_comp = -2;
	localparam int oldest_comp = -3;

	logic clock;
	logic rst;
	logic [rob_pkg::ss_width-1:0] dispatch_req;
	logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] old_tag;
	logic [rob_pkg::ss_width-1:0][rob_pkg::arch_idx_bits-1:0] arch_dest;
	logic [rob_pkg::ss_width-1:0] halt;
	logic [rob_pkg::ss_width-1:0] dispatch_grant;
	logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] alloc_tag;
	logic [rob_pkg::ss_width-1:0] complete_valid;
	logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] complete_tag;
	logic [rob_pkg::ss_width-1:0] retire_valid;
	logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] retire_old_tag;
	logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] retire_new_tag;
	logic [rob_pkg::ss_width-1:0][rob_pkg::arch_idx_bits-1:0] retire_arch_dest;
	logic [rob_pkg::ss_width-1:0] retire_halt;
	logic [rob_pkg::rob_count_bits-1:0] free_rows;
	logic [6:0] free_count;

	// Stimulus table, one entry per cycle
	string step_name[$];
	logic [1:0] step_req[$];
	int step_old0[$];
	int step_old1[$];
	int step_dest0[$];
	int step_dest1[$];
	logic [1:0] step_halt[$];
	int step_comp0[$];
	int step_comp1[$];

	// Reference model: free tag FIFO and in-flight instructions, oldest first
	int free_q[$];
	int rob_new[$];
	int rob_old[$];
	int rob_dest[$];
	logic rob_halt[$];
	logic rob_ready[$];

	// New tag of every granted dispatch, by sequence number
	int seq_tag[$];

	// Completion lanes resolved for the current step
	logic [1:0] cmp_valid;
	int cmp_tag [2];

	int cycle_count = 0;
	int cycle_limit = 1000;

	retire_core uut (
		.clock            (clock),
		.rst              (rst),
		.dispatch_req     (dispatch_req),
		.old_tag          (old_tag),
		.arch_dest        (arch_dest),
		.halt             (halt),
		.dispatch_grant   (dispatch_grant),
		.alloc_tag        (alloc_tag),
		.complete_valid   (complete_valid),
		.complete_tag     (complete_tag),
		.retire_valid     (retire_valid),
		.retire_old_tag   (retire_old_tag),
		.retire_new_tag   (retire_new_tag),
		.retire_arch_dest (retire_arch_dest),
		.retire_halt      (retire_halt),
		.free_rows        (free_rows),
		.free_count       (free_count)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timed out after %0d cycles before the stimulus table ended", cycle_count);
			$display("Finished with errors");
			$fatal(1, "Timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic add_step(input string name, input logic [1:0] req,
			input int old0, input int old1, input int dest0, input int dest1,
			input logic [1:0] hlt, input int comp0, input int comp1);
		step_name.push_back(name);
		step_req.push_back(req);
		step_old0.push_back(old0);
		step_old1.push_back(old1);
		step_dest0.push_back(dest0);
		step_dest1.push_back(dest1);
		step_halt.push_back(hlt);
		step_comp0.push_back(comp0);
		step_comp1.push_back(comp1);
	endtask

	task automatic build_table();
		add_step("reset_state", 2'b00, 0, 0, 0, 0, 2'b00, no_comp, no_comp);
		// First pair takes the two oldest free tags
		add_step("first_pair", 2'b11, 1, 2, 1, 2, 2'b00, no_comp, no_comp);
		add_step("second_pair", 2'b11, 3, 4, 3, 4, 2'b01, no_comp, no_comp);
		// Younger rows complete first and wait behind the head
		add_step("out_of_order", 2'b00, 0, 0, 0, 0, 2'b00, 3, 1);
		add_step("head_waits", 2'b00, 0, 0, 0, 0, 2'b00, no_comp, no_comp);
		// Head completes now and leaves together with its ready neighbour
		add_step("head_done", 2'b00, 0, 0, 0, 0, 2'b00, 0, no_comp);
		add_step("next_pair", 2'b00, 0, 0, 0, 0, 2'b00, 2, no_comp);
		// Sixteen dispatches and no completion
		for (int k = 0; k < 8; k++) begin
			add_step("fill", 2'b11, 5 + 2 * k, 6 + 2 * k, 5 + 2 * k, 6 + 2 * k,
				{k[0], 1'b0}, no_comp, no_comp);
		end
		add_step("table_full", 2'b11, 21, 22, 21, 22, 2'b00, no_comp, no_comp);
		add_step("full_lane0", 2'b01, 21, 22, 21, 22, 2'b00, no_comp, no_comp);
		// Grant still sees a full table while the head retires
		add_step("free_one", 2'b11, 21, 22, 21, 22, 2'b00, 4, no_comp);
		add_step("one_row", 2'b11, 21, 22, 21, 22, 2'b00, no_comp, no_comp);
		add_step("free_two", 2'b10, 23, 24, 23, 24, 2'b00, 5, 6);
		add_step("lone_lane1", 2'b10, 23, 24, 23, 24, 2'b10, no_comp, no_comp);
		for (int k = 0; k < 4; k++) begin
			add_step("mixed", 2'b11, 25 + 2 * k, 26 + 2 * k, (25 + 2 * k) % 32,
				(26 + 2 * k) % 32, 2'b00, rand_comp, rand_comp);
		end
		for (int k = 0; k < 8; k++) begin
			add_step("drain", 2'b00, 0, 0, 0, 0, 2'b00, rand_comp, rand_comp);
		end
		// Steady flow, allocation runs on into the returned old tags
		for (int k = 0; k < 10; k++) begin
			add_step("reuse", 2'b11, 2 * k, 2 * k + 1, 2 * k, 2 * k + 1, 2'b00,
				oldest_comp, oldest_comp);
		end
		for (int k = 0; k < 10; k++) begin
			add_step("drain_end", 2'b00, 0, 0, 0, 0, 2'b00, oldest_comp, oldest_comp);
		end
		add_step("idle", 2'b00, 0, 0, 0, 0, 2'b00, no_comp, no_comp);
	endtask

	function automatic logic tag_hit(input int t);
		return (cmp_valid[0] && cmp_tag[0] == t) || (cmp_valid[1] && cmp_tag[1] == t);
	endfunction

	// Turn the table's selectors into tags on the completion bus
	task automatic resolve_completion(input int sel0, input int sel1);
		int cand[$];
		int sel;
		int pick;
		for (int k = 0; k < rob_new.size(); k++) begin
			if (!rob_ready[k]) begin
				cand.push_back(rob_new[k]);
			end
		end
		for (int l = 0; l < 2; l++) begin
			sel = (l == 0) ? sel0 : sel1;
			cmp_valid[l] = 1'b0;
			cmp_tag[l] = 0;
			if (sel >= 0 && sel < seq_tag.size()) begin
				cmp_valid[l] = 1'b1;
				cmp_tag[l] = seq_tag[sel];
			end else if (sel == rand_comp && cand.size() > 0) begin
				cmp_valid[l] = 1'b1;
				cmp_tag[l] = cand[$urandom % cand.size()];
			end else if (sel == oldest_comp) begin
				// Second lane takes the next oldest when both ask for the oldest
				pick = (l == 1 && sel0 == oldest_comp) ? 1 : 0;
				if (pick < cand.size()) begin
					cmp_valid[l] = 1'b1;
					cmp_tag[l] = cand[pick];
				end
			end
		end
	endtask

	task automatic drive_step(input int i);
		resolve_completion(step_comp0[i], step_comp1[i]);
		dispatch_req <= step_req[i];
		old_tag[0] <= rob_pkg::phys_tag_bits'(step_old0[i]);
		old_tag[1] <= rob_pkg::phys_tag_bits'(step_old1[i]);
		arch_dest[0] <= rob_pkg::arch_idx_bits'(step_dest0[i]);
		arch_dest[1] <= rob_pkg::arch_idx_bits'(step_dest1[i]);
		halt <= step_halt[i];
		complete_valid <= cmp_valid;
		complete_tag[0] <= rob_pkg::phys_tag_bits'(cmp_tag[0]);
		complete_tag[1] <= rob_pkg::phys_tag_bits'(cmp_tag[1]);
	endtask

	task automatic advance_model(input int i, input logic [1:0] grant, input logic [1:0] ret);
		int returned[$];
		int t;
		for (int k = 0; k < rob_new.size(); k++) begin
			if (tag_hit(rob_new[k])) begin
				rob_ready[k] = 1'b1;
			end
		end
		for (int l = 0; l < 2; l++) begin
			if (ret[l]) begin
				returned.push_back(rob_old[0]);
				rob_new.delete(0);
				rob_old.delete(0);
				rob_dest.delete(0);
				rob_halt.delete(0);
				rob_ready.delete(0);
			end
		end
		// Granted lanes take tags from the head of the free FIFO
		for (int l = 0; l < 2; l++) begin
			if (grant[l]) begin
				t = free_q.pop_front();
				seq_tag.push_back(t);
				rob_new.push_back(t);
				rob_old.push_back((l == 0) ? step_old0[i] : step_old1[i]);
				rob_dest.push_back((l == 0) ? step_dest0[i] : step_dest1[i]);
				rob_halt.push_back(step_halt[i][l]);
				rob_ready.push_back(1'b0);
			end
		end
		foreach (returned[k]) begin
			free_q.push_back(returned[k]);
		end
	endtask

	task automatic check_step(input int i);
		string name;
		logic [1:0] req;
		logic [1:0] exp_grant;
		logic [1:0] exp_ret;
		int rows_free;
		int tags_free;
		name = step_name[i];
		req = step_req[i];
		rows_free = rob_pkg::rob_rows - rob_new.size();
		tags_free = free_q.size();
		exp_grant[0] = req[0] && rows_free >= 1 && tags_free >= 1;
		if (req[0]) begin
			exp_grant[1] = req[1] && exp_grant[0] && rows_free >= 2 && tags_free >= 2;
		end else begin
			exp_grant[1] = req[1] && rows_free >= 1 && tags_free >= 1;
		end
		check_value({name, " free_rows"}, rows_free, free_rows);
		check_value({name, " free_count"}, tags_free, free_count);
		check_value({name, " dispatch_grant"}, exp_grant, dispatch_grant);
		if (exp_grant[0]) begin
			check_value({name, " alloc_tag0"}, free_q[0], alloc_tag[0]);
		end
		if (exp_grant[1]) begin
			check_value({name, " alloc_tag1"}, exp_grant[0] ? free_q[1] : free_q[0],
				alloc_tag[1]);
		end
		// Leading run of ready rows at the head, up to two
		exp_ret = 2'b00;
		if (rob_new.size() > 0) begin
			exp_ret[0] = rob_ready[0] || tag_hit(rob_new[0]);
		end
		if (rob_new.size() > 1) begin
			exp_ret[1] = exp_ret[0] && (rob_ready[1] || tag_hit(rob_new[1]));
		end
		check_value({name, " retire_valid"}, exp_ret, retire_valid);
		for (int l = 0; l < 2; l++) begin
			if (exp_ret[l]) begin
				check_value({name, " retire_old_tag"}, rob_old[l], retire_old_tag[l]);
				check_value({name, " retire_new_tag"}, rob_new[l], retire_new_tag[l]);
				check_value({name, " retire_arch_dest"}, rob_dest[l], retire_arch_dest[l]);
				check_value({name, " retire_halt"}, rob_halt[l], retire_halt[l]);
			end
		end
		advance_model(i, exp_grant, exp_ret);
	endtask

	initial begin
		int unsigned first_draw;
		first_draw = $urandom(32'he3e7);
		rst <= 1'b1;
		dispatch_req <= '0;
		old_tag <= '0;
		arch_dest <= '0;
		halt <= '0;
		complete_valid <= '0;
		complete_tag <= '0;
		build_table();
		cycle_limit = step_name.size() + 50;
		// Free list after reset holds the upper half of the tags in order
		for (int k = 0; k < rob_pkg::free_regs_at_reset; k++) begin
			free_q.push_back(rob_pkg::first_free_tag + k);
		end
		repeat (2) @(posedge clock);
		rst <= 1'b0;
		for (int i = 0; i < step_name.size(); i++) begin
			drive_step(i);
			@(negedge clock);
			check_step(i);
			@(posedge clock);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: rob.sv
`default_nettype none

module rob (
	input wire logic clock,
	input wire logic rst,

	// Dispatch
	input wire logic [rob_pkg::ss_width-1:0] dispatch_req,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] new_tag,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] old_tag,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::arch_idx_bits-1:0] arch_dest,
	input wire logic [rob_pkg::ss_width-1:0] halt,
	input wire logic [6:0] free_tags,
	output logic [rob_pkg::ss_width-1:0] dispatch_grant,

	// Completion bus
	input wire logic [rob_pkg::ss_width-1:0] complete_valid,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] complete_tag,

	// Retire
	output logic [rob_pkg::ss_width-1:0] retire_valid,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] retire_old_tag,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] retire_new_tag,
	output logic [rob_pkg::ss_width-1:0][rob_pkg::arch_idx_bits-1:0] retire_arch_dest,
	output logic [rob_pkg::ss_width-1:0] retire_halt,

	output logic [rob_pkg::rob_count_bits-1:0] free_rows
);

	// Row state
	logic [rob_pkg::rob_rows-1:0] row_busy;
	logic [rob_pkg::rob_rows-1:0] row_ready;

	// Row payload
	logic [rob_pkg::rob_rows-1:0][rob_pkg::phys_tag_bits-1:0] row_new_tag;
	logic [rob_pkg::rob_rows-1:0][rob_pkg::phys_tag_bits-1:0] row_old_tag;
	logic [rob_pkg::rob_rows-1:0][rob_pkg::arch_idx_bits-1:0] row_dest;
	logic [rob_pkg::rob_rows-1:0] row_halt;

	// Head is the oldest row, tail the next row to fill
	logic [rob_pkg::rob_idx_bits-1:0] head;
	logic [rob_pkg::rob_idx_bits-1:0] tail;

	logic [rob_pkg::ss_width-1:0][rob_pkg::rob_idx_bits-1:0] dispatch_idx;
	logic [rob_pkg::ss_width-1:0][rob_pkg::rob_idx_bits-1:0] retire_idx;

	logic [rob_pkg::rob_rows-1:0] cam_hit;
	logic [rob_pkg::rob_rows-1:0] ready_now;

	logic room_one;
	logic room_two;
	logic [1:0] n_disp;
	logic [1:0] n_ret;

	// Completion tags against every row's new tag
	tag_cam u_tag_cam (
		.tag_valid (complete_valid),
		.tag       (complete_tag),
		.row_tag   (row_new_tag),
		.row_hit   (cam_hit)
	);

	// Grant from registered row count and free tag count only
	assign room_one = (free_rows >= 5'd1) && (free_tags >= 7'd1);
	assign room_two = (free_rows >= 5'd2) && (free_tags >= 7'd2);

	always_comb begin
		dispatch_grant[0] = dispatch_req[0] && room_one;
		if (dispatch_req[0]) begin
			dispatch_grant[1] = dispatch_req[1] && dispatch_grant[0] && room_two;
		end else begin
			// Lone lane 1 request takes the first free row
			dispatch_grant[1] = dispatch_req[1] && room_one;
		end
	end

	// Granted lanes fill the tail with no gap
	assign dispatch_idx[0] = tail;
	assign dispatch_idx[1] = tail + {3'd0, dispatch_grant[0]};

	assign n_disp = {1'b0, dispatch_grant[0]} + {1'b0, dispatch_grant[1]};

	// Completed earlier or being broadcast right now
	assign ready_now = row_busy & (row_ready | cam_hit);

	assign retire_idx[0] = head;
	assign retire_idx[1] = head + 4'd1;

	// Retire stops at the first row that is not ready
	always_comb begin
		retire_valid[0] = ready_now[retire_idx[0]];
		retire_valid[1] = retire_valid[0] && ready_now[retire_idx[1]];
	end

	always_comb begin
		for (int l = 0; l < rob_pkg::ss_width; l++) begin
			retire_old_tag[l] = row_old_tag[retire_idx[l]];
			retire_new_tag[l] = row_new_tag[retire_idx[l]];
			retire_arch_dest[l] = row_dest[retire_idx[l]];
			retire_halt[l] = row_halt[retire_idx[l]];
		end
	end

	assign n_ret = {1'b0, retire_valid[0]} + {1'b0, retire_valid[1]};

	// Busy and ready bits, pointers and row count
	always_ff @(posedge clock) begin
		if (rst) begin
			row_busy <= '0;
			row_ready <= '0;
			head <= '0;
			tail <= '0;
			free_rows <= rob_pkg::rob_count_bits'(rob_pkg::rob_rows);
		end else begin
			// Rows only pick up hits while they hold an instruction
			row_ready <= row_ready | (row_busy & cam_hit);

			// Retired rows and dispatched rows never coincide, since
			// dispatch only targets rows that are free at the edge
			for (int l = 0; l < rob_pkg::ss_width; l++) begin
				if (retire_valid[l]) begin
					row_busy[retire_idx[l]] <= 1'b0;
				end
			end
			for (int l = 0; l < rob_pkg::ss_width; l++) begin
				if (dispatch_grant[l]) begin
					row_busy[dispatch_idx[l]] <= 1'b1;
					row_ready[dispatch_idx[l]] <= 1'b0;
				end
			end

			head <= head + {2'd0, n_ret};
			tail <= tail + {2'd0, n_disp};
			free_rows <= free_rows - {3'd0, n_disp} + {3'd0, n_ret};
		end
	end

	// Payload for newly dispatched rows
	always_ff @(posedge clock) begin
		for (int l = 0; l < rob_pkg::ss_width; l++) begin
			if (dispatch_grant[l]) begin
				row_new_tag[dispatch_idx[l]] <= new_tag[l];
				row_old_tag[dispatch_idx[l]] <= old_tag[l];
				row_dest[dispatch_idx[l]] <= arch_dest[l];
				row_halt[dispatch_idx[l]] <= halt[l];
			end
		end
	end

endmodule

`default_nettype wire

// File: rob_pkg.sv
`default_nettype none

package rob_pkg;

	// Superscalar width, instructions handled per cycle
	localparam int unsigned ss_width = 2;

	// Reorder buffer geometry
	localparam int unsigned rob_rows = 16;
	localparam int unsigned rob_idx_bits = 4;

	// Occupancy and free row counts run from 0 to rob_rows
	localparam int unsigned rob_count_bits = 5;

	// Register files
	localparam int unsigned num_phys_regs = 64;
	localparam int unsigned num_arch_regs = 32;

	// Physical tag and architectural register widths
	localparam int unsigned phys_tag_bits = 6;
	localparam int unsigned arch_idx_bits = 5;

	// The architectural state holds one tag per architectural register,
	// the rest start out free
	localparam int unsigned free_regs_at_reset = num_phys_regs - num_arch_regs;

	// Tags 0 to 31 map the architectural registers after reset
	localparam int unsigned first_free_tag = 32;

endpackage

`default_nettype wire

// File: sources.f
rob_pkg.sv
tag_cam.sv
free_list.sv
rob.sv
retire_core.sv
retire_core_tb.sv

// File: tag_cam.sv
`default_nettype none

module tag_cam (
	input wire logic [rob_pkg::ss_width-1:0] tag_valid,
	input wire logic [rob_pkg::ss_width-1:0][rob_pkg::phys_tag_bits-1:0] tag,
	input wire logic [rob_pkg::rob_rows-1:0][rob_pkg::phys_tag_bits-1:0] row_tag,
	output logic [rob_pkg::rob_rows-1:0] row_hit
);

	// One compare per row and lane
	logic [rob_pkg::rob_rows-1:0][rob_pkg::ss_width-1:0] lane_hit;

	always_comb begin
		for (int r = 0; r < rob_pkg::rob_rows; r++) begin
			for (int l = 0; l < rob_pkg::ss_width; l++) begin
				lane_hit[r][l] = tag_valid[l] && (tag[l] == row_tag[r]);
			end
		end
	end

	// Row matches if any valid lane carries its tag
	always_comb begin
		for (int r = 0; r < rob_pkg::rob_rows; r++) begin
			row_hit[r] = |lane_hit[r];
		end
	end

endmodule

`default_nettype wire
